// ==== common/drac_pkg.sv ====
// Shared types, register map and ESPM frame layout, imported by every RTL module of the receive path
package drac_pkg;

    // ------------------------------------------------------------
    // Basic word types
    // ------------------------------------------------------------
    typedef logic [31:0] word_t;    // Register and frame data
    typedef logic [15:0] addr_t;    // Register address
    typedef logic [5:0]  slot_t;    // Word index inside a frame
    typedef logic [23:0] pos_t;     // Encoder position

    localparam int FRAME_WORDS = 64;
    localparam int NUM_ENC     = 7; // Channels 1..7

    // ------------------------------------------------------------
    // Register regions, address bits 15:12
    // ------------------------------------------------------------
    localparam logic [3:0] ADDR_MAIN           = 4'h4;
    localparam logic [3:0] ADDR_ESPM           = 4'h9;
    localparam logic [3:0] ADDR_BOARD_SPECIFIC = 4'hB;

    // Main region offsets, address bits 3:0 (channel in bits 7:4)
    localparam logic [3:0] OFF_ENC_LOAD = 4'h4;
    localparam logic [3:0] OFF_ENC_DATA = 4'h5;

    // ------------------------------------------------------------
    // Frame slot map
    // ------------------------------------------------------------
    localparam slot_t SLOT_POS_BASE   = 6'd8;   // Channel c sits at base + c
    localparam slot_t SLOT_ESII       = 6'h21;  // Bit 1 is the ESII link flag
    localparam slot_t SLOT_INST_MODEL = 6'h22;
    localparam slot_t SLOT_INST_ID    = 6'h23;

    // ------------------------------------------------------------
    // Fixed values
    // ------------------------------------------------------------
    localparam pos_t  ENC_MIDRANGE = 24'h800000;
    localparam word_t FILL_WORD    = 32'h0000cccc;  // Unmapped reads
    localparam word_t BUILD_NUMBER = 32'd2;

endpackage

// ==== espm/espm_rx_buffer.sv ====
// ESPM receive buffer: stages incoming frame words and copies good frames into the readable shadow
`timescale 1ns/1ps

module espm_rx_buffer
    import drac_pkg::*;
(
    input  logic  sysclk,
    input  logic  rst,
    input  logic  rx_load,
    input  slot_t rx_sel,
    input  word_t rx_data,
    input  logic  rx_crc_good,
    input  slot_t shadow_raddr,
    output word_t shadow_rdata,
    output pos_t  pos [1:NUM_ENC],
    output word_t esii_status,
    output word_t inst_model,
    output word_t inst_id,
    output logic  frame_copied
);

    typedef enum logic {ST_IDLE, ST_COPY} copy_state_t;

    word_t stage_ram  [0:FRAME_WORDS-1];
    word_t shadow_ram [0:FRAME_WORDS-1];

    logic        load_q;
    slot_t       sel_q;
    word_t       data_q;
    copy_state_t state;
    slot_t       copy_slot;
    word_t       copy_word;

    // ------------------------------------------------------------
    // Staging side, one register stage before the RAM write
    // ------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (rst) begin
            load_q <= 1'b0;
        end else begin
            load_q <= rx_load;
        end
        sel_q  <= rx_sel;
        data_q <= rx_data;
        if (load_q) begin
            stage_ram[sel_q] <= data_q;
        end
    end

    assign copy_word = stage_ram[copy_slot];

    // ------------------------------------------------------------
    // Copy engine, one slot per cycle after a good CRC
    // ------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (rst) begin
            state        <= ST_IDLE;
            copy_slot    <= '0;
            frame_copied <= 1'b0;
        end else begin
            frame_copied <= 1'b0;
            case (state)
                ST_IDLE: begin
                    copy_slot <= '0;
                    if (rx_crc_good) begin
                        state <= ST_COPY;
                    end
                end
                ST_COPY: begin
                    copy_slot <= copy_slot + 6'd1;
                    if (copy_slot == slot_t'(FRAME_WORDS - 1)) begin
                        state        <= ST_IDLE;
                        frame_copied <= 1'b1;   // Shadow and decoded words now stable
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge sysclk) begin
        if (state == ST_COPY) begin
            shadow_ram[copy_slot] <= copy_word;
        end
    end

    // Decode while the copy passes the mapped slots
    always_ff @(posedge sysclk) begin
        if (rst) begin
            esii_status <= '0;
            inst_model  <= '0;
            inst_id     <= '0;
            for (int c = 1; c <= NUM_ENC; c++) begin
                pos[c] <= '0;
            end
        end else if (state == ST_COPY) begin
            for (int c = 1; c <= NUM_ENC; c++) begin
                if (copy_slot == slot_t'(SLOT_POS_BASE + c)) begin
                    pos[c] <= copy_word[23:0];
                end
            end
            if (copy_slot == SLOT_ESII)       esii_status <= copy_word;
            if (copy_slot == SLOT_INST_MODEL) inst_model  <= copy_word;
            if (copy_slot == SLOT_INST_ID)    inst_id     <= copy_word;
        end
    end

    assign shadow_rdata = shadow_ram[shadow_raddr];    // Register path reads directly

endmodule

// ==== espm/espm_comm_watchdog.sv ====
// ESPM link watchdog: counts good and bad frames and flags whether good frames arrive each window
`timescale 1ns/1ps

module espm_comm_watchdog
    import drac_pkg::*;
#(
    parameter int WDOG_PERIOD = 1024
) (
    input  logic  sysclk,
    input  logic  rst,
    input  logic  rx_eof,
    input  logic  rx_crc_good,
    output word_t crc_good_count,
    output word_t crc_err_count,
    output logic  comm_good
);

    localparam int CNT_W = $clog2(WDOG_PERIOD);

    logic [CNT_W-1:0] win_cnt;
    logic             seen_good;    // Good frame within current window
    logic             win_end;

    assign win_end = (win_cnt == CNT_W'(WDOG_PERIOD - 1));

    // ------------------------------------------------------------
    // Frame counters
    // ------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (rst) begin
            crc_good_count <= '0;
            crc_err_count  <= '0;
        end else begin
            if (rx_crc_good) begin
                crc_good_count <= crc_good_count + 32'd1;
            end
            if (rx_eof && !rx_crc_good) begin
                crc_err_count <= crc_err_count + 32'd1;
            end
        end
    end

    // ------------------------------------------------------------
    // Window check
    // ------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (rst) begin
            win_cnt   <= '0;
            seen_good <= 1'b0;
            comm_good <= 1'b0;
        end else if (win_end) begin
            win_cnt   <= '0;
            comm_good <= seen_good | rx_crc_good;   // Include a frame on the last cycle
            seen_good <= 1'b0;
        end else begin
            win_cnt   <= win_cnt + 1'b1;
            seen_good <= seen_good | rx_crc_good;
        end
    end

endmodule

// ==== rtl/encoder_preload.sv ====
// Encoder preload: holds per-channel preload and offset, and returns the preload-adjusted position
`timescale 1ns/1ps

module encoder_preload
    import drac_pkg::*;
(
    input  logic       sysclk,
    input  logic       rst,
    input  logic       reg_wen,
    input  addr_t      reg_waddr,
    input  word_t      reg_wdata,
    input  pos_t       pos [1:NUM_ENC],
    input  logic [3:0] enc_sel,
    output pos_t       enc_preload,
    output pos_t       enc_position
);

    pos_t       preload [1:NUM_ENC];
    pos_t       offset  [1:NUM_ENC];
    logic       load_wr;
    logic [3:0] wr_ch;

    assign load_wr = reg_wen && (reg_waddr[15:12] == ADDR_MAIN)
                     && (reg_waddr[3:0] == OFF_ENC_LOAD);
    assign wr_ch   = reg_waddr[7:4];

    // ------------------------------------------------------------
    // Preload write
    // ------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (rst) begin
            for (int c = 1; c <= NUM_ENC; c++) begin
                preload[c] <= ENC_MIDRANGE;
                offset[c]  <= '0;
            end
        end else if (load_wr) begin
            for (int c = 1; c <= NUM_ENC; c++) begin
                if (wr_ch == 4'(c)) begin
                    preload[c] <= reg_wdata[23:0];
                    offset[c]  <= reg_wdata[23:0] - pos[c];    // Wraps mod 2^24
                end
            end
        end
    end

    // ------------------------------------------------------------
    // Read side, channel from the registered read address
    // ------------------------------------------------------------
    always_comb begin
        enc_preload  = '0;  // Channel 0 and 8..15 unmapped
        enc_position = '0;
        for (int c = 1; c <= NUM_ENC; c++) begin
            if (enc_sel == 4'(c)) begin
                enc_preload  = preload[c];
                enc_position = pos[c] + offset[c];
            end
        end
    end

endmodule

// ==== rtl/drac_reg_read.sv ====
// Register read path: registers the read address, selects the region source and registers the data
`timescale 1ns/1ps

module drac_reg_read
    import drac_pkg::*;
(
    input  logic  sysclk,
    input  logic  rst,
    input  addr_t reg_raddr,
    input  word_t shadow_rdata,
    input  word_t esii_status,
    input  word_t inst_model,
    input  word_t inst_id,
    input  word_t crc_good_count,
    input  word_t crc_err_count,
    input  pos_t  enc_preload,
    input  pos_t  enc_position,
    output addr_t raddr_q,
    output word_t reg_rdata
);

    // Board-specific register offsets, address bits 11:0
    localparam logic [11:0] BS_CRC_ERR    = 12'h000;
    localparam logic [11:0] BS_CRC_GOOD   = 12'h001;
    localparam logic [11:0] BS_ESII       = 12'h010;
    localparam logic [11:0] BS_INST_MODEL = 12'h012;
    localparam logic [11:0] BS_INST_ID    = 12'h013;
    localparam logic [11:0] BS_BUILD      = 12'hfff;

    word_t main_rdata;
    word_t board_rdata;
    word_t mux_rdata;

    always_comb begin
        case (raddr_q[3:0])
            OFF_ENC_LOAD: main_rdata = {8'h00, enc_preload};
            OFF_ENC_DATA: main_rdata = {8'h00, enc_position};
            default:      main_rdata = FILL_WORD;
        endcase
    end

    always_comb begin
        case (raddr_q[11:0])
            BS_CRC_ERR:    board_rdata = crc_err_count;
            BS_CRC_GOOD:   board_rdata = crc_good_count;
            BS_ESII:       board_rdata = esii_status;
            BS_INST_MODEL: board_rdata = inst_model;
            BS_INST_ID:    board_rdata = inst_id;
            BS_BUILD:      board_rdata = BUILD_NUMBER;
            default:       board_rdata = FILL_WORD;
        endcase
    end

    // ------------------------------------------------------------
    // Region select
    // ------------------------------------------------------------
    always_comb begin
        case (raddr_q[15:12])
            ADDR_MAIN:           mux_rdata = main_rdata;
            ADDR_ESPM:           mux_rdata = shadow_rdata;  // Slot from bits 5:0
            ADDR_BOARD_SPECIFIC: mux_rdata = board_rdata;
            default:             mux_rdata = '0;
        endcase
    end

    // Address at edge N, data at edge N+1
    always_ff @(posedge sysclk) begin
        if (rst) begin
            raddr_q   <= '0;
            reg_rdata <= '0;
        end else begin
            raddr_q   <= reg_raddr;
            reg_rdata <= mux_rdata;
        end
    end

endmodule

// ==== rtl/drac_espm_top.sv ====
// Top of the ESPM receive path: wires the frame buffer, link watchdog, encoder preload and reads
`timescale 1ns/1ps

module drac_espm_top
    import drac_pkg::*;
#(
    parameter int WDOG_PERIOD = 1024
) (
    input  logic  sysclk,
    input  logic  rst,
    // Word-level receive port
    input  logic  rx_load,
    input  slot_t rx_sel,
    input  word_t rx_data,
    input  logic  rx_eof,
    input  logic  rx_crc_good,
    // Register bus
    input  logic  reg_wen,
    input  addr_t reg_waddr,
    input  word_t reg_wdata,
    input  addr_t reg_raddr,
    output word_t reg_rdata,
    // Status
    output logic  comm_good,
    output logic  esii_good,
    output logic  frame_copied
);

    addr_t raddr_q;
    word_t shadow_rdata;
    pos_t  pos [1:NUM_ENC];
    word_t esii_status;
    word_t inst_model;
    word_t inst_id;
    word_t crc_good_count;
    word_t crc_err_count;
    pos_t  enc_preload;
    pos_t  enc_position;

    assign esii_good = esii_status[1];

    espm_rx_buffer espm_rx_buffer_inst (
        .sysclk(sysclk), .rst(rst),
        .rx_load(rx_load), .rx_sel(rx_sel), .rx_data(rx_data), .rx_crc_good(rx_crc_good),
        .shadow_raddr(raddr_q[5:0]), .shadow_rdata(shadow_rdata),
        .pos(pos), .esii_status(esii_status), .inst_model(inst_model), .inst_id(inst_id),
        .frame_copied(frame_copied)
    );

    espm_comm_watchdog #(.WDOG_PERIOD(WDOG_PERIOD)) espm_comm_watchdog_inst (
        .sysclk(sysclk), .rst(rst),
        .rx_eof(rx_eof), .rx_crc_good(rx_crc_good),
        .crc_good_count(crc_good_count), .crc_err_count(crc_err_count),
        .comm_good(comm_good)
    );

    encoder_preload encoder_preload_inst (
        .sysclk(sysclk), .rst(rst),
        .reg_wen(reg_wen), .reg_waddr(reg_waddr), .reg_wdata(reg_wdata),
        .pos(pos), .enc_sel(raddr_q[7:4]),     // Channel of the registered read
        .enc_preload(enc_preload), .enc_position(enc_position)
    );

    drac_reg_read drac_reg_read_inst (
        .sysclk(sysclk), .rst(rst), .reg_raddr(reg_raddr),
        .shadow_rdata(shadow_rdata), .esii_status(esii_status),
        .inst_model(inst_model), .inst_id(inst_id),
        .crc_good_count(crc_good_count), .crc_err_count(crc_err_count),
        .enc_preload(enc_preload), .enc_position(enc_position),
        .raddr_q(raddr_q), .reg_rdata(reg_rdata)
    );

endmodule

// ==== test/drac_espm_properties.sv ====
// Concurrent assertions on the control outputs of the ESPM receive top, bound in from the testbench
`timescale 1ns/1ps

module drac_espm_properties (
    input logic sysclk,
    input logic rst,
    input logic rx_crc_good,
    input logic frame_copied,
    input logic comm_good,
    input logic esii_good
);

    int   assert_fails = 0;
    logic crc_pending;     // Good CRC seen, copy not yet finished

    always_ff @(posedge sysclk) begin
        if (rst) begin
            crc_pending <= 1'b0;
        end else if (rx_crc_good) begin
            crc_pending <= 1'b1;
        end else if (frame_copied) begin
            crc_pending <= 1'b0;
        end
    end

    // ------------------------------------------------------------
    // Control output rules
    // ------------------------------------------------------------
    a_copied_one_cycle: assert property (@(posedge sysclk) disable iff (rst)
        frame_copied |=> !frame_copied)
        else begin
            assert_fails = assert_fails + 1;
            $error("frame_copied held for more than one cycle");
        end

    a_low_after_reset: assert property (@(posedge sysclk)
        rst |=> (!frame_copied && !comm_good && !esii_good))
        else begin
            assert_fails = assert_fails + 1;
            $error("control outputs not low in the cycle after reset");
        end

    a_copy_needs_crc: assert property (@(posedge sysclk) disable iff (rst)
        frame_copied |-> crc_pending)
        else begin
            assert_fails = assert_fails + 1;
            $error("frame_copied without a preceding good CRC");
        end

endmodule

// ==== test/tb_drac_espm.sv ====
// Testbench top for the ESPM receive path that replays frames, register writes and reads from the vector file
`timescale 1ns/1ps

module tb_drac_espm;
    import drac_pkg::*;

    localparam int WDOG = 256;

    logic  sysclk = 1'b0;
    logic  rst;
    logic  rx_load;
    slot_t rx_sel;
    word_t rx_data;
    logic  rx_eof;
    logic  rx_crc_good;
    logic  reg_wen;
    addr_t reg_waddr;
    word_t reg_wdata;
    addr_t reg_raddr;
    word_t reg_rdata;
    logic  comm_good;
    logic  esii_good;
    logic  frame_copied;

    // Expected state kept from the frames and writes sent so far
    word_t sent     [0:FRAME_WORDS-1];
    word_t shadow_m [0:FRAME_WORDS-1];
    pos_t  pos_m    [1:NUM_ENC];
    pos_t  pre_m    [1:NUM_ENC];
    pos_t  off_m    [1:NUM_ENC];
    word_t rng;
    int    cycles = 0;
    int    limit = 0;

    always #4 sysclk = ~sysclk;     // 8 ns period

    drac_espm_top #(.WDOG_PERIOD(WDOG)) drac_espm_top_inst (
        .sysclk(sysclk), .rst(rst),
        .rx_load(rx_load), .rx_sel(rx_sel), .rx_data(rx_data),
        .rx_eof(rx_eof), .rx_crc_good(rx_crc_good),
        .reg_wen(reg_wen), .reg_waddr(reg_waddr), .reg_wdata(reg_wdata),
        .reg_raddr(reg_raddr), .reg_rdata(reg_rdata),
        .comm_good(comm_good), .esii_good(esii_good), .frame_copied(frame_copied)
    );

    bind drac_espm_top drac_espm_properties drac_espm_properties_inst (
        .sysclk(sysclk), .rst(rst), .rx_crc_good(rx_crc_good),
        .frame_copied(frame_copied), .comm_good(comm_good), .esii_good(esii_good)
    );

    // ------------------------------------------------------------
    // Failure handling and compare tasks
    // ------------------------------------------------------------
    task automatic stop_on_failure();
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    always @(posedge sysclk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles > limit) begin
            $display("timeout, the run went past %0d cycles without finishing", limit);
            stop_on_failure();
        end else if (drac_espm_top_inst.drac_espm_properties_inst.assert_fails != 0) begin
            $display("a bound assertion on the top-level control outputs failed");
            stop_on_failure();
        end
    end

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("error: %s got %h expected %h", name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_pos(input string name, input pos_t got, input pos_t exp);
        if (got !== exp) begin
            $display("error: %s got %h expected %h", name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error: %s got %h expected %h", name, got, exp);
            stop_on_failure();
        end
    endtask

    function automatic word_t lcg_next(input word_t state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // ------------------------------------------------------------
    // Bus tasks entered and left 1 ns after a rising edge
    // ------------------------------------------------------------
    task automatic read_reg(input addr_t addr, output word_t data);
        reg_raddr = addr;
        @(posedge sysclk);  // Address registered
        @(posedge sysclk);  // Data registered
        #1;
        data = reg_rdata;
    endtask

    task automatic write_reg(input addr_t addr, input word_t data);
        int ch;
        reg_wen   = 1'b1;
        reg_waddr = addr;
        reg_wdata = data;
        @(posedge sysclk);
        #1;
        reg_wen = 1'b0;
        ch = int'(addr[7:4]);
        if (addr[15:12] == ADDR_MAIN && addr[3:0] == OFF_ENC_LOAD && ch >= 1 && ch <= NUM_ENC) begin
            pre_m[ch] = data[23:0];
            off_m[ch] = data[23:0] - pos_m[ch];     // Mod 2^24
        end
    endtask

    task automatic send_frame(input logic good);
        int waited;
        waited = 0;
        for (int s = 0; s < FRAME_WORDS; s++) begin
            rng     = lcg_next(rng);
            sent[s] = rng;
            rx_load = 1'b1;
            rx_sel  = slot_t'(s);
            rx_data = rng;
            @(posedge sysclk);
            #1;
        end
        rx_load     = 1'b0;
        rx_eof      = 1'b1;
        rx_crc_good = good;
        @(posedge sysclk);
        #1;
        rx_eof      = 1'b0;
        rx_crc_good = 1'b0;
        if (good) begin
            while (frame_copied !== 1'b1) begin
                if (waited == 2 * FRAME_WORDS + 8) begin
                    $display("frame_copied never pulsed after a good frame");
                    stop_on_failure();
                end else begin
                    @(posedge sysclk);
                    #1;
                    waited++;
                end
            end
            for (int s = 0; s < FRAME_WORDS; s++) begin
                shadow_m[s] = sent[s];
            end
            for (int c = 1; c <= NUM_ENC; c++) begin
                pos_m[c] = sent[int'(SLOT_POS_BASE) + c][23:0];
            end
        end
    endtask

    task automatic check_shadow();
        word_t got;
        addr_t addr;
        for (int s = 0; s < FRAME_WORDS; s++) begin
            addr = {ADDR_ESPM, 6'h00, slot_t'(s)};
            read_reg(addr, got);
            check_word($sformatf("reg_rdata @%h", addr), got, shadow_m[s]);
        end
        read_reg({ADDR_BOARD_SPECIFIC, 12'h010}, got);
        check_word("esii_status", got, shadow_m[SLOT_ESII]);
        read_reg({ADDR_BOARD_SPECIFIC, 12'h012}, got);
        check_word("inst_model", got, shadow_m[SLOT_INST_MODEL]);
        read_reg({ADDR_BOARD_SPECIFIC, 12'h013}, got);
        check_word("inst_id", got, shadow_m[SLOT_INST_ID]);
        check_flag("esii_good", esii_good, shadow_m[SLOT_ESII][1]);
    endtask

    task automatic check_channel(input int ch);
        word_t got;
        read_reg({ADDR_MAIN, 4'h0, 4'(ch), OFF_ENC_LOAD}, got);
        check_word("enc_preload upper byte", got & 32'hff00_0000, 32'h0000_0000);
        check_pos("enc_preload", got[23:0], pre_m[ch]);
        read_reg({ADDR_MAIN, 4'h0, 4'(ch), OFF_ENC_DATA}, got);
        check_word("enc_position upper byte", got & 32'hff00_0000, 32'h0000_0000);
        check_pos("enc_position", got[23:0], pos_m[ch] + off_m[ch]);
    endtask

    task automatic wait_comm_good();
        int waited;
        waited = 0;
        while (comm_good !== 1'b1 && waited < 2 * WDOG + 8) begin
            @(posedge sysclk);
            #1;
            waited++;
        end
        check_flag("comm_good", comm_good, 1'b1);
    endtask

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial begin
        int         fd;
        int         n;
        int         status;
        string      line;
        logic [7:0] cmd;
        word_t      arg_a;
        word_t      arg_b;
        word_t      got;
        rst         = 1'b1;
        rx_load     = 1'b0;
        rx_sel      = '0;
        rx_data     = '0;
        rx_eof      = 1'b0;
        rx_crc_good = 1'b0;
        reg_wen     = 1'b0;
        reg_waddr   = '0;
        reg_wdata   = '0;
        reg_raddr   = '0;
        rng         = 32'hbaee_73e7;
        n           = 0;
        for (int c = 1; c <= NUM_ENC; c++) begin
            pos_m[c] = '0;
            pre_m[c] = ENC_MIDRANGE;
            off_m[c] = '0;
        end
        fd = $fopen("test/espm_vectors.txt", "r");
        if (fd == 0) begin
            $display("the vector file test/espm_vectors.txt could not be opened");
            stop_on_failure();
        end
        while (!$feof(fd)) begin
            if ($fgets(line, fd) != 0) begin
                n++;
            end
        end
        $fclose(fd);
        limit = 20 * n * 70;
        fd = $fopen("test/espm_vectors.txt", "r");
        repeat (10) @(posedge sysclk);
        #1;
        rst = 1'b0;
        while (!$feof(fd)) begin
            status = $fgets(line, fd);
            if (status != 0 && line.len() > 1 && line[0] != "#") begin
                status = $sscanf(line, "%c %h %h", cmd, arg_a, arg_b);
                case (cmd)
                    "F": send_frame(arg_a[0]);
                    "S": check_shadow();
                    "R": begin
                        read_reg(arg_a[15:0], got);
                        check_word($sformatf("reg_rdata @%h", arg_a[15:0]), got, arg_b);
                    end
                    "W": write_reg(arg_a[15:0], arg_b);
                    "P": check_channel(int'(arg_a[3:0]));
                    "C": check_flag("comm_good", comm_good, arg_a[0]);
                    "G": wait_comm_good();
                    "I": begin
                        repeat (arg_a) @(posedge sysclk);
                        #1;
                    end
                    default: begin
                        $display("unknown command in the vector file: %s", line);
                        stop_on_failure();
                    end
                endcase
            end
        end
        $fclose(fd);
        if (drac_espm_top_inst.drac_espm_properties_inst.assert_fails == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== test/espm_vectors.txt ====
# Columns, arguments in hex: F good_crc | S | R addr expected | W addr data
# P channel | C comm_good | G (wait for comm_good) | I idle_cycles
C 0
P 3
F 1
S
P 3
R b000 00000000
F 0
S
R b000 00000001
R b001 00000001
W 4034 00123456
P 3
F 1
S
P 3
W 4074 00fffff0
P 7
R b001 00000002
G
R 4000 0000cccc
R b123 0000cccc
R bfff 00000002
R 1000 00000000
I 258
C 0

// ==== list.f ====
common/drac_pkg.sv
espm/espm_rx_buffer.sv
espm/espm_comm_watchdog.sv
rtl/encoder_preload.sv
rtl/drac_reg_read.sv
rtl/drac_espm_top.sv
test/drac_espm_properties.sv
test/tb_drac_espm.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log for the pass message
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert -j 0 --top-module tb_drac_espm -f list.f -o tb_sim \
    && ./obj_dir/tb_sim +verilator+error+limit+100 > sim.log 2>&1 \
    || echo "build or simulation ended with an error" >> sim.log
cat sim.log
grep -q "ALL CHECKS PASSED" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
